/* exec_complete.f */
+incdir+include
source/exec_complete_pkg.sv
source/phys_regfile.sv
source/alu_unit.sv
source/mul_unit.sv
source/complete_stage.sv
source/exec_complete_top.sv
dv/exec_complete_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := exec_complete_tb
FILELIST  := exec_complete.f
BUILD_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* dv/exec_complete_tb.sv */
`default_nettype none
`include "exec_complete_settings.svh"

module exec_complete_tb
    import exec_complete_pkg::*;
();

    // reset, five directed tests, then sixty random ops of at most the mul latency
    localparam int TOTAL_CYCLES  = 16 + 8 + 6 + 7 + 5 + 10 + 60 * `EC_MUL_STAGES;
    localparam int WATCHDOG_TIME = 40 * (TOTAL_CYCLES + 100);

    logic        clock;
    logic        rst_n;

    logic        alu_issue_valid;
    alu_op_e     alu_op;
    preg_t       alu_src1;
    preg_t       alu_src2;
    word_t       alu_imm;
    preg_t       alu_dest;
    rob_idx_t    alu_rob_idx;
    logic        alu_pred_taken;

    logic        mul_issue_valid;
    mul_op_e     mul_op;
    preg_t       mul_src1;
    preg_t       mul_src2;
    preg_t       mul_dest;
    rob_idx_t    mul_rob_idx;

    logic [1:0]  wb_valid;
    rob_idx_t    wb_rob_idx [2];
    logic [1:0]  wb_exception;
    logic [1:0]  wb_mispred;
    logic [1:0]  cdb_valid;
    preg_t       cdb_tag    [2];
    word_t       cdb_value  [2];

    word_t       ref_regs [`EC_PHYS_REGS];
    bit          written  [`EC_PHYS_REGS];
    preg_t       live_tags [$];
    logic [31:0] lcg_state;
    rob_idx_t    next_rob;

    exec_complete_top DUT (
        .clk_i             (clock),
        .rst_n_i           (rst_n),
        .alu_issue_valid_i (alu_issue_valid),
        .alu_op_i          (alu_op),
        .alu_src1_i        (alu_src1),
        .alu_src2_i        (alu_src2),
        .alu_imm_i         (alu_imm),
        .alu_dest_i        (alu_dest),
        .alu_rob_idx_i     (alu_rob_idx),
        .alu_pred_taken_i  (alu_pred_taken),
        .mul_issue_valid_i (mul_issue_valid),
        .mul_op_i          (mul_op),
        .mul_src1_i        (mul_src1),
        .mul_src2_i        (mul_src2),
        .mul_dest_i        (mul_dest),
        .mul_rob_idx_i     (mul_rob_idx),
        .wb_valid_o        (wb_valid),
        .wb_rob_idx_o      (wb_rob_idx),
        .wb_exception_o    (wb_exception),
        .wb_mispred_o      (wb_mispred),
        .cdb_valid_o       (cdb_valid),
        .cdb_tag_o         (cdb_tag),
        .cdb_value_o       (cdb_value)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        #(WATCHDOG_TIME);
        abort_run("watchdog expired before the tests finished");
    end

    // ============================================================
    // reporting and compare tasks
    // ============================================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t expv);
        if (got !== expv) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expv));
        end
    endtask

    task automatic check_tag(input string name, input preg_t got, input preg_t expv);
        if (got !== expv) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expv));
        end
    endtask

    task automatic check_rob_idx(input string name, input rob_idx_t got, input rob_idx_t expv);
        if (got !== expv) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expv));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expv);
        if (got !== expv) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expv));
        end
    endtask

    // ============================================================
    // reference model
    // ============================================================
    function automatic word_t alu_expect(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ALU_ADD, ALU_ADDI: return a + b;
            ALU_SUB:           return a - b;
            ALU_AND:           return a & b;
            ALU_OR:            return a | b;
            ALU_XOR:           return a ^ b;
            ALU_SLT:           return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
            default:           return (a == b) ? word_t'(1) : word_t'(0);  // beq outcome
        endcase
    endfunction

    function automatic logic add_overflows(input word_t a, input word_t b);
        longint sum;
        sum = longint'($signed(a)) + longint'($signed(b));
        return sum != longint'($signed(word_t'(sum)));  // sum does not fit one word
    endfunction

    function automatic word_t mul_expect(input mul_op_e op, input word_t a, input word_t b);
        longint prod;
        prod = longint'($signed(a)) * longint'($signed(b));
        return (op == MUL_HI) ? word_t'(prod >>> `EC_XLEN) : word_t'(prod);
    endfunction

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'h0, lcg_state[31:16]};
    endfunction

    function automatic rob_idx_t alloc_rob();
        rob_idx_t idx;
        idx = next_rob;
        next_rob = next_rob + 1'b1;
        return idx;
    endfunction

    task automatic commit_result(input preg_t dest, input word_t value);
        if (dest != '0) begin
            ref_regs[dest] = value;
            if (!written[dest]) begin
                written[dest] = 1'b1;
                live_tags.push_back(dest);
            end
        end
    endtask

    // ============================================================
    // drive and expect helpers
    // ============================================================
    task automatic next_cycle();
        @(posedge clock);
        #5;
    endtask

    task automatic expect_idle(input int lane);
        check_flag($sformatf("wb_valid_o[%0d]", lane), wb_valid[lane], 1'b0);
        check_flag($sformatf("cdb_valid_o[%0d]", lane), cdb_valid[lane], 1'b0);
    endtask

    task automatic expect_lane(input int lane, input preg_t dest, input word_t value,
                               input rob_idx_t rob, input logic exc, input logic mis);
        logic writes;
        writes = (dest != '0);  // tag 0 keeps its report but no broadcast
        check_flag($sformatf("wb_valid_o[%0d]", lane), wb_valid[lane], 1'b1);
        check_rob_idx($sformatf("wb_rob_idx_o[%0d]", lane), wb_rob_idx[lane], rob);
        check_flag($sformatf("wb_exception_o[%0d]", lane), wb_exception[lane], exc);
        check_flag($sformatf("wb_mispred_o[%0d]", lane), wb_mispred[lane], mis);
        check_flag($sformatf("cdb_valid_o[%0d]", lane), cdb_valid[lane], writes);
        check_tag($sformatf("cdb_tag_o[%0d]", lane), cdb_tag[lane], writes ? dest : '0);
        check_word($sformatf("cdb_value_o[%0d]", lane), cdb_value[lane],
                   writes ? value : '0);
    endtask

    task automatic issue_alu(input alu_op_e op, input preg_t s1, input preg_t s2,
                             input word_t imm, input preg_t dest, input rob_idx_t rob,
                             input logic pred, output word_t value, output logic exc,
                             output logic mis);
        word_t a;
        word_t b;
        a     = ref_regs[s1];
        b     = (op == ALU_ADDI) ? imm : ref_regs[s2];
        value = alu_expect(op, a, b);
        exc   = (op == ALU_ADD) && add_overflows(a, b);
        mis   = (op == ALU_BEQ) && ((a == b) != pred);
        alu_issue_valid = 1'b1;
        alu_op          = op;
        alu_src1        = s1;
        alu_src2        = s2;
        alu_imm         = imm;
        alu_dest        = dest;
        alu_rob_idx     = rob;
        alu_pred_taken  = pred;
    endtask

    task automatic issue_mul(input mul_op_e op, input preg_t s1, input preg_t s2,
                             input preg_t dest, input rob_idx_t rob, output word_t value);
        value           = mul_expect(op, ref_regs[s1], ref_regs[s2]);
        mul_issue_valid = 1'b1;
        mul_op          = op;
        mul_src1        = s1;
        mul_src2        = s2;
        mul_dest        = dest;
        mul_rob_idx     = rob;
    endtask

    task automatic run_alu(input alu_op_e op, input preg_t s1, input preg_t s2,
                           input word_t imm, input preg_t dest, input logic pred);
        rob_idx_t rob;
        word_t    value;
        logic     exc;
        logic     mis;
        rob = alloc_rob();
        issue_alu(op, s1, s2, imm, dest, rob, pred, value, exc, mis);
        next_cycle();
        alu_issue_valid = 1'b0;
        expect_lane(0, dest, value, rob, exc, mis);
        expect_idle(1);
        commit_result(dest, value);
    endtask

    task automatic run_mul(input mul_op_e op, input preg_t s1, input preg_t s2,
                           input preg_t dest);
        rob_idx_t rob;
        word_t    value;
        rob = alloc_rob();
        issue_mul(op, s1, s2, dest, rob, value);
        next_cycle();
        mul_issue_valid = 1'b0;
        repeat (`EC_MUL_STAGES - 1) begin
            expect_idle(1);
            next_cycle();
        end
        expect_lane(1, dest, value, rob, 1'b0, 1'b0);
        expect_idle(0);
        commit_result(dest, value);
    endtask

    // ============================================================
    // tests
    // ============================================================
    task automatic test_reset_and_addi();
        expect_idle(0);
        expect_idle(1);
        run_alu(ALU_ADDI, 5'd20, 5'd0, 32'h0, 5'd8, 1'b0);  // cleared reg reads zero
        run_alu(ALU_ADDI, 5'd0, 5'd0, 32'h0000_1234, 5'd1, 1'b0);
        run_alu(ALU_ADDI, 5'd0, 5'd0, 32'h00ff_00ff, 5'd2, 1'b0);
        run_alu(ALU_ADDI, 5'd0, 5'd0, 32'hf0f0_f0f0, 5'd3, 1'b0);
        run_alu(ALU_ADDI, 5'd0, 5'd0, 32'hffff_fff9, 5'd4, 1'b0);
        run_alu(ALU_ADDI, 5'd0, 5'd0, 32'h7fff_ffff, 5'd5, 1'b0);
        run_alu(ALU_ADDI, 5'd0, 5'd0, 32'h8000_0000, 5'd6, 1'b0);
        run_alu(ALU_ADDI, 5'd0, 5'd0, 32'h0000_0005, 5'd7, 1'b0);
    endtask

    task automatic test_dependent_chain();
        run_alu(ALU_SUB, 5'd1, 5'd2, '0, 5'd9, 1'b0);
        run_alu(ALU_AND, 5'd9, 5'd3, '0, 5'd10, 1'b0);
        run_alu(ALU_OR, 5'd10, 5'd4, '0, 5'd11, 1'b0);
        run_alu(ALU_XOR, 5'd11, 5'd1, '0, 5'd12, 1'b0);
        run_alu(ALU_SLT, 5'd12, 5'd4, '0, 5'd13, 1'b0);
        run_alu(ALU_SLT, 5'd4, 5'd13, '0, 5'd29, 1'b0);
    endtask

    task automatic test_mul_pipeline();
        mul_op_e  ops  [3];
        preg_t    src1 [3];
        preg_t    src2 [3];
        preg_t    dest [3];
        rob_idx_t rob  [3];
        word_t    expv [3];
        ops  = '{MUL_LO, MUL_HI, MUL_HI};
        src1 = '{5'd4, 5'd4, 5'd6};
        src2 = '{5'd1, 5'd2, 5'd6};
        dest = '{5'd14, 5'd15, 5'd16};
        for (int i = 0; i < 3; i++) begin
            rob[i] = alloc_rob();
            issue_mul(ops[i], src1[i], src2[i], dest[i], rob[i], expv[i]);
            next_cycle();
            if (i < 2) begin
                expect_idle(1);  // first product not due yet
            end
        end
        mul_issue_valid = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (i > 0) begin
                next_cycle();
            end
            expect_lane(1, dest[i], expv[i], rob[i], 1'b0, 1'b0);
            expect_idle(0);
            commit_result(dest[i], expv[i]);
        end
        next_cycle();
        expect_idle(1);
    endtask

    task automatic test_dual_lane();
        rob_idx_t mul_rob;
        rob_idx_t alu_rob;
        word_t    mul_value;
        word_t    alu_value;
        logic     exc;
        logic     mis;
        mul_rob = alloc_rob();
        issue_mul(MUL_LO, 5'd7, 5'd1, 5'd17, mul_rob, mul_value);
        next_cycle();
        mul_issue_valid = 1'b0;
        expect_idle(1);
        next_cycle();
        expect_idle(1);
        alu_rob = alloc_rob();
        issue_alu(ALU_ADDI, 5'd7, 5'd0, 32'd100, 5'd18, alu_rob, 1'b0, alu_value, exc, mis);
        next_cycle();
        alu_issue_valid = 1'b0;
        expect_lane(0, 5'd18, alu_value, alu_rob, exc, mis);
        expect_lane(1, 5'd17, mul_value, mul_rob, 1'b0, 1'b0);
        commit_result(5'd18, alu_value);
        commit_result(5'd17, mul_value);
        run_alu(ALU_ADD, 5'd17, 5'd18, '0, 5'd19, 1'b0);  // both through bypass
        run_alu(ALU_XOR, 5'd17, 5'd18, '0, 5'd20, 1'b0);  // from the array
    endtask

    task automatic test_flags();
        run_alu(ALU_ADD, 5'd5, 5'd7, '0, 5'd21, 1'b0);
        run_alu(ALU_ADD, 5'd6, 5'd6, '0, 5'd22, 1'b0);
        run_alu(ALU_ADD, 5'd1, 5'd7, '0, 5'd23, 1'b0);
        run_alu(ALU_ADDI, 5'd5, 5'd0, 32'd1, 5'd24, 1'b0);  // wraps, no trap
        run_alu(ALU_SUB, 5'd6, 5'd7, '0, 5'd25, 1'b0);
        run_alu(ALU_BEQ, 5'd7, 5'd7, '0, 5'd0, 1'b1);
        run_alu(ALU_ADDI, 5'd0, 5'd0, 32'h0, 5'd28, 1'b0);  // tag 0 still zero
        run_alu(ALU_BEQ, 5'd7, 5'd7, '0, 5'd26, 1'b0);
        run_alu(ALU_BEQ, 5'd7, 5'd1, '0, 5'd27, 1'b1);
        run_alu(ALU_BEQ, 5'd7, 5'd1, '0, 5'd0, 1'b0);
    endtask

    task automatic test_random_ops();
        logic [31:0] hi;
        logic [31:0] lo;
        preg_t       s1;
        preg_t       s2;
        preg_t       dest;
        logic [2:0]  op_bits;
        for (int n = 0; n < 60; n++) begin
            s1      = live_tags[next_rand() % live_tags.size()];
            s2      = live_tags[next_rand() % live_tags.size()];
            dest    = preg_t'(next_rand());
            op_bits = 3'(next_rand());
            hi      = next_rand();
            lo      = next_rand();
            if (next_rand() % 2 == 0) begin
                run_alu(alu_op_e'(op_bits), s1, s2, {hi[15:0], lo[15:0]}, dest, lo[7]);
            end else begin
                run_mul(mul_op_e'(op_bits[0]), s1, s2, dest);
            end
        end
    endtask

    initial begin
        lcg_state       = 32'd3;
        next_rob        = '0;
        alu_issue_valid = 1'b0;
        alu_op          = ALU_ADD;
        alu_src1        = '0;
        alu_src2        = '0;
        alu_imm         = '0;
        alu_dest        = '0;
        alu_rob_idx     = '0;
        alu_pred_taken  = 1'b0;
        mul_issue_valid = 1'b0;
        mul_op          = MUL_LO;
        mul_src1        = '0;
        mul_src2        = '0;
        mul_dest        = '0;
        mul_rob_idx     = '0;
        for (int r = 0; r < `EC_PHYS_REGS; r++) begin
            ref_regs[r] = '0;
            written[r]  = 1'b0;
        end
        written[0] = 1'b1;
        live_tags.push_back('0);

        rst_n = 1'b0;
        repeat (16) @(posedge clock);
        #5;
        rst_n = 1'b1;

        test_reset_and_addi();
        test_dependent_chain();
        test_mul_pipeline();
        test_dual_lane();
        test_flags();
        test_random_ops();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* source/exec_complete_top.sv */
`default_nettype none

module exec_complete_top
    import exec_complete_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,

    input  logic        alu_issue_valid_i,
    input  alu_op_e     alu_op_i,
    input  preg_t       alu_src1_i,
    input  preg_t       alu_src2_i,
    input  word_t       alu_imm_i,
    input  preg_t       alu_dest_i,
    input  rob_idx_t    alu_rob_idx_i,
    input  logic        alu_pred_taken_i,

    input  logic        mul_issue_valid_i,
    input  mul_op_e     mul_op_i,
    input  preg_t       mul_src1_i,
    input  preg_t       mul_src2_i,
    input  preg_t       mul_dest_i,
    input  rob_idx_t    mul_rob_idx_i,

    output logic [1:0]  wb_valid_o,
    output rob_idx_t    wb_rob_idx_o [2],
    output logic [1:0]  wb_exception_o,
    output logic [1:0]  wb_mispred_o,

    output logic [1:0]  cdb_valid_o,
    output preg_t       cdb_tag_o    [2],
    output word_t       cdb_value_o  [2]
);

    // ============================================================
    // operand read, ports 0/1 alu and 2/3 mul
    // ============================================================
    preg_t      rd_tag  [4];
    word_t      rd_data [4];
    logic [1:0] prf_wr_en;
    preg_t      prf_wr_tag  [2];
    word_t      prf_wr_data [2];

    assign rd_tag = '{alu_src1_i, alu_src2_i, mul_src1_i, mul_src2_i};

    phys_regfile u_prf (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rd_tag_i  (rd_tag),
        .rd_data_o (rd_data),
        .wr_en_i   (prf_wr_en),
        .wr_tag_i  (prf_wr_tag),
        .wr_data_i (prf_wr_data)
    );

    // ============================================================
    // functional units
    // ============================================================
    logic     alu_valid;
    word_t    alu_value;
    preg_t    alu_dest;
    rob_idx_t alu_rob;
    logic     alu_exc;
    logic     alu_mis;
    logic     mul_valid;
    word_t    mul_value;
    preg_t    mul_dest;
    rob_idx_t mul_rob;

    alu_unit u_alu (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .issue_valid_i   (alu_issue_valid_i),
        .op_i            (alu_op_i),
        .src1_data_i     (rd_data[0]),
        .src2_data_i     (rd_data[1]),
        .imm_i           (alu_imm_i),
        .dest_i          (alu_dest_i),
        .rob_idx_i       (alu_rob_idx_i),
        .pred_taken_i    (alu_pred_taken_i),
        .res_valid_o     (alu_valid),
        .res_value_o     (alu_value),
        .res_dest_o      (alu_dest),
        .res_rob_idx_o   (alu_rob),
        .res_exception_o (alu_exc),
        .res_mispred_o   (alu_mis)
    );

    mul_unit u_mul (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (mul_issue_valid_i),
        .op_i          (mul_op_i),
        .src1_data_i   (rd_data[2]),
        .src2_data_i   (rd_data[3]),
        .dest_i        (mul_dest_i),
        .rob_idx_i     (mul_rob_idx_i),
        .res_valid_o   (mul_valid),
        .res_value_o   (mul_value),
        .res_dest_o    (mul_dest),
        .res_rob_idx_o (mul_rob)
    );

    complete_stage u_complete (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .alu_valid_i     (alu_valid),
        .alu_value_i     (alu_value),
        .alu_dest_i      (alu_dest),
        .alu_rob_idx_i   (alu_rob),
        .alu_exception_i (alu_exc),
        .alu_mispred_i   (alu_mis),
        .mul_valid_i     (mul_valid),
        .mul_value_i     (mul_value),
        .mul_dest_i      (mul_dest),
        .mul_rob_idx_i   (mul_rob),
        .prf_wr_en_o     (prf_wr_en),
        .prf_wr_tag_o    (prf_wr_tag),
        .prf_wr_data_o   (prf_wr_data),
        .wb_valid_o      (wb_valid_o),
        .wb_rob_idx_o    (wb_rob_idx_o),
        .wb_exception_o  (wb_exception_o),
        .wb_mispred_o    (wb_mispred_o),
        .cdb_valid_o     (cdb_valid_o),
        .cdb_tag_o       (cdb_tag_o),
        .cdb_value_o     (cdb_value_o)
    );

endmodule

`default_nettype wire

/* source/complete_stage.sv */
`default_nettype none

module complete_stage
    import exec_complete_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,

    // alu lane
    input  logic        alu_valid_i,
    input  word_t       alu_value_i,
    input  preg_t       alu_dest_i,
    input  rob_idx_t    alu_rob_idx_i,
    input  logic        alu_exception_i,
    input  logic        alu_mispred_i,

    // mul lane
    input  logic        mul_valid_i,
    input  word_t       mul_value_i,
    input  preg_t       mul_dest_i,
    input  rob_idx_t    mul_rob_idx_i,

    output logic [1:0]  prf_wr_en_o,
    output preg_t       prf_wr_tag_o   [2],
    output word_t       prf_wr_data_o  [2],

    output logic [1:0]  wb_valid_o,
    output rob_idx_t    wb_rob_idx_o   [2],
    output logic [1:0]  wb_exception_o,
    output logic [1:0]  wb_mispred_o,

    output logic [1:0]  cdb_valid_o,
    output preg_t       cdb_tag_o      [2],
    output word_t       cdb_value_o    [2]
);

    logic [1:0] lane_valid;
    word_t      lane_value [2];
    preg_t      lane_dest  [2];
    rob_idx_t   lane_rob   [2];
    logic [1:0] lane_exc;
    logic [1:0] lane_mis;
    logic       writes;

    assign lane_valid = {mul_valid_i, alu_valid_i};
    assign lane_value = '{alu_value_i, mul_value_i};
    assign lane_dest  = '{alu_dest_i, mul_dest_i};
    assign lane_rob   = '{alu_rob_idx_i, mul_rob_idx_i};
    assign lane_exc   = {1'b0, alu_exception_i};  // mul never traps
    assign lane_mis   = {1'b0, alu_mispred_i};

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            writes            = lane_valid[i] && (lane_dest[i] != '0);
            prf_wr_en_o[i]    = writes;
            prf_wr_tag_o[i]   = writes ? lane_dest[i] : '0;
            prf_wr_data_o[i]  = writes ? lane_value[i] : '0;
            // rob still hears about tag 0 results
            wb_valid_o[i]     = lane_valid[i];
            wb_rob_idx_o[i]   = lane_valid[i] ? lane_rob[i] : '0;
            wb_exception_o[i] = lane_valid[i] && lane_exc[i];
            wb_mispred_o[i]   = lane_valid[i] && lane_mis[i];
            cdb_valid_o[i]    = writes;
            cdb_tag_o[i]      = writes ? lane_dest[i] : '0;
            cdb_value_o[i]    = writes ? lane_value[i] : '0;
        end
    end

    a_distinct_rob: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_valid_o == 2'b11) |-> (wb_rob_idx_o[0] != wb_rob_idx_o[1]));

endmodule

`default_nettype wire

/* source/mul_unit.sv */
`default_nettype none
`include "exec_complete_settings.svh"

module mul_unit
    import exec_complete_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,

    input  logic      issue_valid_i,
    input  mul_op_e   op_i,
    input  word_t     src1_data_i,
    input  word_t     src2_data_i,
    input  preg_t     dest_i,
    input  rob_idx_t  rob_idx_i,

    output logic      res_valid_o,
    output word_t     res_value_o,
    output preg_t     res_dest_o,
    output rob_idx_t  res_rob_idx_o
);

    // stage 1 operands
    logic      s1_valid_q;
    mul_op_e   s1_op_q;
    word_t     s1_a_q;
    word_t     s1_b_q;
    preg_t     s1_dest_q;
    rob_idx_t  s1_rob_q;

    // stage 2 full product
    logic                        s2_valid_q;
    mul_op_e                     s2_op_q;
    logic signed [2*`EC_XLEN-1:0] s2_prod_q;
    preg_t                       s2_dest_q;
    rob_idx_t                    s2_rob_q;

    logic signed [2*`EC_XLEN-1:0] product;

    assign product = $signed(s1_a_q) * $signed(s1_b_q);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s1_valid_q  <= 1'b0;
            s2_valid_q  <= 1'b0;
            res_valid_o <= 1'b0;
        end else begin
            s1_valid_q  <= issue_valid_i;
            s2_valid_q  <= s1_valid_q;
            res_valid_o <= s2_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_op_q       <= op_i;
        s1_a_q        <= src1_data_i;
        s1_b_q        <= src2_data_i;
        s1_dest_q     <= dest_i;
        s1_rob_q      <= rob_idx_i;
        s2_op_q       <= s1_op_q;
        s2_prod_q     <= product;
        s2_dest_q     <= s1_dest_q;
        s2_rob_q      <= s1_rob_q;
        res_value_o   <= (s2_op_q == MUL_HI) ? s2_prod_q[2*`EC_XLEN-1:`EC_XLEN]
                                             : s2_prod_q[`EC_XLEN-1:0];
        res_dest_o    <= s2_dest_q;
        res_rob_idx_o <= s2_rob_q;
    end

endmodule

`default_nettype wire

/* source/alu_unit.sv */
`default_nettype none
`include "exec_complete_settings.svh"

module alu_unit
    import exec_complete_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,

    input  logic      issue_valid_i,
    input  alu_op_e   op_i,
    input  word_t     src1_data_i,
    input  word_t     src2_data_i,
    input  word_t     imm_i,
    input  preg_t     dest_i,
    input  rob_idx_t  rob_idx_i,
    input  logic      pred_taken_i,

    output logic      res_valid_o,
    output word_t     res_value_o,
    output preg_t     res_dest_o,
    output rob_idx_t  res_rob_idx_o,
    output logic      res_exception_o,
    output logic      res_mispred_o
);

    word_t operand_b;
    word_t result;
    logic  overflow;
    logic  taken;
    logic  mispred;

    assign operand_b = (op_i == ALU_ADDI) ? imm_i : src2_data_i;
    assign taken     = (src1_data_i == operand_b);
    assign mispred   = (op_i == ALU_BEQ) && (taken != pred_taken_i);

    // ============================================================
    // execute
    // ============================================================
    always_comb begin
        result   = '0;
        overflow = 1'b0;
        case (op_i)
            ALU_ADD: begin
                result   = src1_data_i + operand_b;
                // same operand signs, different result sign
                overflow = (src1_data_i[`EC_XLEN-1] == operand_b[`EC_XLEN-1]) &&
                           (result[`EC_XLEN-1] != src1_data_i[`EC_XLEN-1]);
            end
            ALU_SUB:  result = src1_data_i - operand_b;
            ALU_AND:  result = src1_data_i & operand_b;
            ALU_OR:   result = src1_data_i | operand_b;
            ALU_XOR:  result = src1_data_i ^ operand_b;
            ALU_ADDI: result = src1_data_i + operand_b;
            ALU_SLT:  result = word_t'($signed(src1_data_i) < $signed(operand_b));
            ALU_BEQ:  result = word_t'(taken);
            default:  result = '0;
        endcase
    end

    // ============================================================
    // result stage
    // ============================================================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            res_valid_o     <= 1'b0;
            res_exception_o <= 1'b0;
            res_mispred_o   <= 1'b0;
        end else begin
            res_valid_o     <= issue_valid_i;
            res_exception_o <= issue_valid_i && overflow;
            res_mispred_o   <= issue_valid_i && mispred;
        end
    end

    always_ff @(posedge clk_i) begin
        res_value_o   <= result;
        res_dest_o    <= dest_i;
        res_rob_idx_o <= rob_idx_i;
    end

    a_flags_need_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (res_exception_o || res_mispred_o) |-> res_valid_o);

endmodule

`default_nettype wire

/* source/phys_regfile.sv */
`default_nettype none
`include "exec_complete_settings.svh"

module phys_regfile
    import exec_complete_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,

    input  preg_t       rd_tag_i  [4],
    output word_t       rd_data_o [4],

    input  logic [1:0]  wr_en_i,
    input  preg_t       wr_tag_i  [2],
    input  word_t       wr_data_i [2]
);

    word_t regs_q [`EC_PHYS_REGS];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            regs_q <= '{default: '0};
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wr_en_i[w] && (wr_tag_i[w] != '0)) begin
                    regs_q[wr_tag_i[w]] <= wr_data_i[w];
                end
            end
        end
    end

    // read with write-through from both lanes
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            rd_data_o[r] = regs_q[rd_tag_i[r]];
            for (int w = 0; w < 2; w++) begin
                if (wr_en_i[w] && (wr_tag_i[w] == rd_tag_i[r])) begin
                    rd_data_o[r] = wr_data_i[w];
                end
            end
            if (rd_tag_i[r] == '0) begin
                rd_data_o[r] = '0;  // zero register
            end
        end
    end

    // issue logic owns distinct destination tags
    a_no_dual_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(wr_en_i[0] && wr_en_i[1] && (wr_tag_i[0] == wr_tag_i[1]) && (wr_tag_i[0] != '0)));

endmodule

`default_nettype wire

/* source/exec_complete_pkg.sv */
`default_nettype none
`include "exec_complete_settings.svh"

package exec_complete_pkg;

    typedef logic [`EC_XLEN-1:0]               word_t;
    typedef logic [$clog2(`EC_PHYS_REGS)-1:0]  preg_t;
    typedef logic [$clog2(`EC_ROB_DEPTH)-1:0]  rob_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,  // traps on signed overflow
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_ADDI = 3'd5,  // src2 replaced by imm
        ALU_SLT  = 3'd6,
        ALU_BEQ  = 3'd7   // checks prediction
    } alu_op_e;

    typedef enum logic {
        MUL_LO = 1'b0,
        MUL_HI = 1'b1
    } mul_op_e;

endpackage

`default_nettype wire

/* include/exec_complete_settings.svh */
`ifndef EXEC_COMPLETE_SETTINGS_SVH
`define EXEC_COMPLETE_SETTINGS_SVH

// data word width
`define EC_XLEN 32

// physical register count, tag 0 is the zero register
`define EC_PHYS_REGS 32

`define EC_ROB_DEPTH 16

// multiplier latency in cycles
`define EC_MUL_STAGES 3

`endif
